// ==== sim/sdio_rx_cases.txt ====
# width(1=4bit) bsize bcount hold rw clk_en delay crc_lane end_lane exp_gap exp_crc exp_end
# lanes count from 1, 0 means none; hold is blk_gap_stop cycles per gap
0 4 1 0 0 1 2 0 0 1 0 0
1 8 2 3 1 1 1 0 0 2 0 0
0 3 2 2 0 0 0 0 0 2 0 0
1 6 3 2 1 0 0 0 0 3 0 0
1 16 2 1 0 1 3 0 0 2 0 0
0 4 1 0 0 1 0 1 0 1 1 0
1 4 1 0 0 1 0 1 0 1 1 0
1 4 1 0 0 1 0 2 0 1 1 0
1 4 1 0 0 1 0 3 0 1 1 0
1 4 1 0 0 1 0 4 0 1 1 0
1 4 2 1 1 1 0 0 3 2 0 2
0 2 1 0 0 1 0 0 1 1 0 1
1 2 1 0 0 1 0 0 4 1 0 1
0 5 3 1 1 0 1 0 0 3 0 0

// ==== sources.f ====
+incdir+include
verilog/sdio_pkg.sv
verilog/sdio_rx_if.sv
verilog/sdio_rx_fsm.sv
verilog/sdio_rx_deser.sv
verilog/sdio_crc_check.sv
verilog/sdio_rx_top.sv
sim/sdio_rx_assert.sv
sim/sdio_rx_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -sv
TOP       ?= sdio_rx_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/sdio_rx_tb.sv ====
`include "sdio_macros.svh"

module sdio_rx_tb import sdio_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    logic       sd_clk;
    logic       rstn;
    logic       sd_rst;
    blk_field_t block_size;
    blk_field_t block_count;
    logic       width4;
    logic       gap_stop;
    logic       gap_clk_en;
    logic       read_wait_en;
    logic       rx_en;
    logic       dat_start;
    logic       dma_rdy;
    logic       dma_empty;
    lanes_t     dat;
    byte_t      dma_rx_buf_o;
    logic       dma_rx_buf_wr_o;
    logic       dat2_o;
    logic       dat2_oe_o;
    logic       dat_crc_err_event_o;
    logic       dat_end_err_event_o;
    logic       blk_gap_event_o;
    logic       dat_busy_o;
    logic       dat_done_o;
    logic       sd_clk_pause_o;
    logic       tmout_wait_rx_start_en_o;

    // current case, as read from the cases file
    int c_width, c_bsize, c_bcount, c_hold, c_rw, c_clk_en, c_delay;
    int c_crc_lane, c_end_lane, e_gap, e_crc, e_end;

    int    err_cnt;
    int    check_cnt;
    int    case_cnt;
    bit    timed_out;
    byte_t exp_q[$];        // bytes sent by the card, not yet written to dma
    int    gap_cnt, crc_ev_cnt, end_ev_cnt, done_cnt;
    int    dma_delay;

    sdio_rx_top dut0 (
        .sd_clk                   (sd_clk),
        .rstn                     (rstn),
        .sd_rst_i                 (sd_rst),
        .block_size_i             (block_size),
        .block_count_i            (block_count),
        .dat_trans_width_i        (width4),
        .blk_gap_stop_i           (gap_stop),
        .blk_gap_clk_en_i         (gap_clk_en),
        .blk_gap_read_wait_en_i   (read_wait_en),
        .rx_en_i                  (rx_en),
        .dat_start_i              (dat_start),
        .dma_rx_buf_rdy_i         (dma_rdy),
        .dma_rx_buf_empty_i       (dma_empty),
        .dma_rx_buf_o             (dma_rx_buf_o),
        .dma_rx_buf_wr_o          (dma_rx_buf_wr_o),
        .dat_i                    (dat),
        .dat2_o                   (dat2_o),
        .dat2_oe_o                (dat2_oe_o),
        .dat_crc_err_event_o      (dat_crc_err_event_o),
        .dat_end_err_event_o      (dat_end_err_event_o),
        .blk_gap_event_o          (blk_gap_event_o),
        .dat_busy_o               (dat_busy_o),
        .dat_done_o               (dat_done_o),
        .sd_clk_pause_o           (sd_clk_pause_o),
        .tmout_wait_rx_start_en_o (tmout_wait_rx_start_en_o)
    );

    initial begin
        sd_clk = 1'b0;
        forever #2 sd_clk = ~sd_clk;
    end

    // card clock runs unless the host pauses it
    initial begin
        rx_en = 1'b0;
        forever begin
            @(posedge sd_clk);
            #1 rx_en = ~sd_clk_pause_o;
        end
    end

    // dma buffer, random ready delay per byte
    initial begin
        dma_delay = 0;
        forever begin
            @(posedge sd_clk);
            #1;
            if (dma_rx_buf_wr_o) begin
                dma_delay = $urandom % 4;
            end
            dma_rdy = (dma_delay == 0);
            if (sd_clk_pause_o && dma_delay > 0) begin
                dma_delay--;
            end
        end
    end

    // outputs sampled mid cycle
    initial begin
        forever begin
            @(negedge sd_clk);
            if (dma_rx_buf_wr_o) begin
                if (exp_q.size() == 0) begin
                    err_cnt++;
                    $display("dma write of byte %h with no byte pending", dma_rx_buf_o);
                end else begin
                    check_byte("dma_rx_buf_o", dma_rx_buf_o, exp_q.pop_front());
                end
            end
            if (blk_gap_event_o) gap_cnt++;
            if (dat_crc_err_event_o) crc_ev_cnt++;
            if (dat_end_err_event_o) end_ev_cnt++;
            if (dat_done_o) done_cnt++;
        end
    end

    task automatic check_byte(string name, byte_t got, byte_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(string name, blk_field_t got, blk_field_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic note_timeout(string what);
        timed_out = 1'b1;
        $display("timeout in case %0d, %s never happened", case_cnt, what);
    endtask

    // x^16+x^12+x^5+1, one input bit
    function automatic crc_t crc_step(crc_t crc, logic din);
        logic fb;
        fb = din ^ crc[`SDIO_CRC_LEN-1];
        return {crc[`SDIO_CRC_LEN-2:0], 1'b0} ^ (fb ? crc_t'(16'h1021) : crc_t'(0));
    endfunction

    // present one sample until the host takes it
    task automatic drive_sample(lanes_t s);
        int n;
        n = 0;
        if (timed_out) return;
        dat = s;
        @(posedge sd_clk);
        while (!rx_en) begin
            n++;
            if (n > 200) begin
                note_timeout("card sample taken");
                return;
            end
            @(posedge sd_clk);
        end
        #1;
    endtask

    task automatic wait_start();
        int n;
        n = 0;
        while (!tmout_wait_rx_start_en_o) begin
            n++;
            if (n > 100) begin
                note_timeout("start bit wait");
                return;
            end
            @(posedge sd_clk);
            #1;
        end
    endtask

    task automatic send_block(bit last);
        crc_t   crc[`SDIO_LANES];
        byte_t  b;
        lanes_t s;
        int     nl;
        wait_start();
        if (timed_out) return;
        gap_stop = (c_hold > 0);
        nl = c_width ? `SDIO_LANES : 1;
        for (int j = 0; j < `SDIO_LANES; j++) crc[j] = '0;
        for (int i = 0; i < c_delay; i++) begin
            drive_sample('1);
            check_bit("tmout_wait_rx_start_en_o", tmout_wait_rx_start_en_o, 1'b1);
        end
        drive_sample(c_width ? 4'h0 : 4'hE);
        check_bit("tmout_wait_rx_start_en_o", tmout_wait_rx_start_en_o, 1'b0);
        for (int i = 0; i < c_bsize; i++) begin
            b = byte_t'($urandom);
            exp_q.push_back(b);
            if (c_width) begin
                for (int h = 1; h >= 0; h--) begin
                    s = b[h*4 +: 4];    // high nibble first
                    for (int j = 0; j < `SDIO_LANES; j++) crc[j] = crc_step(crc[j], s[j]);
                    drive_sample(s);
                end
            end else begin
                for (int k = 7; k >= 0; k--) begin
                    crc[0] = crc_step(crc[0], b[k]);
                    drive_sample({3'b111, b[k]});
                end
            end
        end
        for (int k = 0; k < `SDIO_CRC_LEN; k++) begin
            s = '1;
            for (int j = 0; j < nl; j++) s[j] = crc[j][`SDIO_CRC_LEN-1-k];
            if (c_crc_lane != 0 && k == 9) begin
                s[c_crc_lane-1] = ~s[c_crc_lane-1];  // one flipped crc bit
            end
            drive_sample(s);
        end
        s = '1;
        if (c_end_lane != 0) s[c_end_lane-1] = 1'b0;
        drive_sample(s);
        dat = '1;
        if (timed_out || last || c_hold == 0) return;
        // now in the gap stop
        check_bit("sd_clk_pause_o", sd_clk_pause_o, !c_clk_en[0]);
        for (int i = 0; i < c_hold; i++) begin
            @(posedge sd_clk);
            #1;
            check_bit("dat2_oe_o", dat2_oe_o, c_rw[0]);
            check_bit("dat2_o", dat2_o, !c_rw[0]);
            check_bit("sd_clk_pause_o", sd_clk_pause_o, !c_clk_en[0]);
        end
        gap_stop = 1'b0;
    endtask

    task automatic run_case();
        int n;
        n = 0;
        width4       = c_width[0];
        block_size   = blk_field_t'(c_bsize);
        block_count  = blk_field_t'(c_bcount);
        gap_clk_en   = c_clk_en[0];
        read_wait_en = c_rw[0];
        gap_stop     = (c_hold > 0);
        gap_cnt      = 0;
        crc_ev_cnt   = 0;
        end_ev_cnt   = 0;
        done_cnt     = 0;
        exp_q.delete();
        @(posedge sd_clk);
        #1 dat_start = 1'b1;
        @(posedge sd_clk);
        #1 dat_start = 1'b0;
        for (int blk = 1; blk <= c_bcount; blk++) begin
            send_block(blk == c_bcount);
            if (timed_out) return;
        end
        dma_empty = 1'b1;
        while (done_cnt == 0) begin
            n++;
            if (n > 50) begin
                note_timeout("dat_done_o pulse");
                return;
            end
            @(posedge sd_clk);
            #1;
        end
        // one more cycle with the buffer empty, a second done pulse gets counted
        @(posedge sd_clk);
        #1 dma_empty = 1'b0;
        check_bit("dat_busy_o", dat_busy_o, 1'b0);
        check_count("blk_gap_event_o count", blk_field_t'(gap_cnt), blk_field_t'(e_gap));
        check_count("dat_crc_err_event_o count", blk_field_t'(crc_ev_cnt),
                    blk_field_t'(e_crc));
        check_count("dat_end_err_event_o count", blk_field_t'(end_ev_cnt),
                    blk_field_t'(e_end));
        check_count("dat_done_o count", blk_field_t'(done_cnt), blk_field_t'(1));
        check_count("bytes not written", blk_field_t'(exp_q.size()), blk_field_t'(0));
    endtask

    initial begin
        int    fd;
        int    r;
        string line;
        rstn         = 1'b0;
        sd_rst       = 1'b0;
        block_size   = '0;
        block_count  = '0;
        width4       = 1'b0;
        gap_stop     = 1'b0;
        gap_clk_en   = 1'b1;
        read_wait_en = 1'b0;
        dat_start    = 1'b0;
        dma_rdy      = 1'b0;
        dma_empty    = 1'b0;
        dat          = '1;
        err_cnt      = 0;
        check_cnt    = 0;
        case_cnt     = 0;
        timed_out    = 1'b0;
        void'($urandom(25749));
        repeat (4) @(posedge sd_clk);
        #1 rstn = 1'b1;
        fd = $fopen("sim/sdio_rx_cases.txt", "r");
        if (fd == 0) begin
            err_cnt++;
            $display("cases file sim/sdio_rx_cases.txt could not be opened");
        end else begin
            while (!$feof(fd) && !timed_out) begin
                r = $fgets(line, fd);
                if (r > 1 && line.substr(0, 0) != "#") begin
                    r = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d",
                                c_width, c_bsize, c_bcount, c_hold, c_rw, c_clk_en,
                                c_delay, c_crc_lane, c_end_lane, e_gap, e_crc, e_end);
                    if (r == 12) begin
                        case_cnt++;
                        run_case();
                    end
                end
            end
            $fclose(fd);
        end
        $display("cases %0d checks %0d errors %0d timeouts %0d",
                 case_cnt, check_cnt, err_cnt, timed_out);
        if (err_cnt == 0 && !timed_out && case_cnt > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== sim/sdio_rx_assert.sv ====
`include "sdio_macros.svh"

module sdio_rx_assert (
    input logic sd_clk,
    input logic rstn,
    input logic dma_rx_buf_wr_o,
    input logic dat_done_o,
    input logic dat_busy_o,
    input logic dat2_oe_o,
    input logic blk_gap_read_wait_en_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // one strobe per byte
    wr_one_cycle: assert property (@(posedge sd_clk) disable iff (!rstn)
        dma_rx_buf_wr_o |=> !dma_rx_buf_wr_o)
        else $error("dma_rx_buf_wr_o held for more than one cycle");

    // done closes the transfer, busy drops right after it
    done_ends_busy: assert property (@(posedge sd_clk) disable iff (!rstn)
        dat_done_o |=> $past(dat_busy_o) && !dat_busy_o)
        else $error("dat_done_o outside a transfer or dat_busy_o still high after it");

    // DAT2 is driven only for read wait
    oe_needs_rw: assert property (@(posedge sd_clk) disable iff (!rstn)
        $rose(dat2_oe_o) |-> blk_gap_read_wait_en_i)
        else $error("dat2_oe_o rose with read wait disabled");

endmodule

bind sdio_rx_top sdio_rx_assert u_assert (
    .sd_clk                 (sd_clk),
    .rstn                   (rstn),
    .dma_rx_buf_wr_o        (dma_rx_buf_wr_o),
    .dat_done_o             (dat_done_o),
    .dat_busy_o             (dat_busy_o),
    .dat2_oe_o              (dat2_oe_o),
    .blk_gap_read_wait_en_i (blk_gap_read_wait_en_i)
);

// ==== verilog/sdio_rx_top.sv ====
`include "sdio_macros.svh"

module sdio_rx_top import sdio_pkg::*; (
    input  logic       sd_clk,
    input  logic       rstn,
    input  logic       sd_rst_i,                // soft reset, synchronous
    // registers
    input  blk_field_t block_size_i,
    input  blk_field_t block_count_i,           // 0: infinite
    input  logic       dat_trans_width_i,       // 1: 4-bit, 0: 1-bit
    input  logic       blk_gap_stop_i,
    input  logic       blk_gap_clk_en_i,
    input  logic       blk_gap_read_wait_en_i,
    // control
    input  logic       rx_en_i,
    input  logic       dat_start_i,
    // dma buffer
    input  logic       dma_rx_buf_rdy_i,
    input  logic       dma_rx_buf_empty_i,
    output byte_t      dma_rx_buf_o,
    output logic       dma_rx_buf_wr_o,
    // pins
    input  lanes_t     dat_i,
    output logic       dat2_o,
    output logic       dat2_oe_o,
    // status
    output logic       dat_crc_err_event_o,
    output logic       dat_end_err_event_o,
    output logic       blk_gap_event_o,
    output logic       dat_busy_o,
    output logic       dat_done_o,
    output logic       sd_clk_pause_o,
    output logic       tmout_wait_rx_start_en_o
);

    sdio_rx_if bus ();

    assign bus.lanes  = dat_i;
    assign bus.width4 = dat_trans_width_i;

    sdio_rx_fsm u_fsm (
        .sd_clk                   (sd_clk),
        .rstn                     (rstn),
        .sd_rst_i                 (sd_rst_i),
        .block_size_i             (block_size_i),
        .block_count_i            (block_count_i),
        .blk_gap_stop_i           (blk_gap_stop_i),
        .blk_gap_clk_en_i         (blk_gap_clk_en_i),
        .blk_gap_read_wait_en_i   (blk_gap_read_wait_en_i),
        .rx_en_i                  (rx_en_i),
        .dat_start_i              (dat_start_i),
        .dma_rx_buf_rdy_i         (dma_rx_buf_rdy_i),
        .dma_rx_buf_empty_i       (dma_rx_buf_empty_i),
        .bus                      (bus),
        .dma_rx_buf_wr_o          (dma_rx_buf_wr_o),
        .dat2_o                   (dat2_o),
        .dat2_oe_o                (dat2_oe_o),
        .dat_crc_err_event_o      (dat_crc_err_event_o),
        .dat_end_err_event_o      (dat_end_err_event_o),
        .blk_gap_event_o          (blk_gap_event_o),
        .dat_busy_o               (dat_busy_o),
        .dat_done_o               (dat_done_o),
        .sd_clk_pause_o           (sd_clk_pause_o),
        .tmout_wait_rx_start_en_o (tmout_wait_rx_start_en_o)
    );

    // byte register feeding the dma buffer
    sdio_rx_deser u_deser (
        .sd_clk       (sd_clk),
        .bus          (bus),
        .dma_rx_buf_o (dma_rx_buf_o)
    );

    sdio_crc_check u_crc (
        .sd_clk   (sd_clk),
        .rstn     (rstn),
        .sd_rst_i (sd_rst_i),
        .bus      (bus)
    );

endmodule

// ==== verilog/sdio_crc_check.sv ====
`include "sdio_macros.svh"

module sdio_crc_check import sdio_pkg::*; (
    input  logic      sd_clk,
    input  logic      rstn,
    input  logic      sd_rst_i,
    sdio_rx_if.crc_mp bus
);

    localparam crc_t CRC_POLY = crc_t'(16'h1021);  // x^16 + x^12 + x^5 + 1

    logic [`SDIO_LANES-1:0] lane_on;
    logic [`SDIO_LANES-1:0] lane_miss;
    logic                   any_miss;

    for (genvar i = 0; i < `SDIO_LANES; i++) begin : g_lane
        crc_t crc_q;
        logic fb;
        logic crc_bit;

        assign lane_on[i] = (i == 0) || bus.width4;  // DAT1..3 only on a 4-bit bus

        assign fb = bus.lanes[i] ^ crc_q[`SDIO_CRC_LEN-1];

        // serial crc16, zero seed at every block
        always_ff @(posedge sd_clk) begin
            if (bus.blk_start) begin
                crc_q <= '0;
            end else if (bus.data_en && lane_on[i]) begin
                crc_q <= {crc_q[`SDIO_CRC_LEN-2:0], 1'b0} ^ (fb ? CRC_POLY : '0);
            end
        end

        // crc goes out msb first
        assign crc_bit = crc_q[crc_idx_t'(`SDIO_CRC_LEN - 1) - bus.crc_idx];

        assign lane_miss[i] = lane_on[i] && (bus.lanes[i] != crc_bit);
    end

    assign any_miss = |lane_miss;

    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn) begin
            bus.crc_err <= 1'b0;
        end else if (sd_rst_i || bus.blk_start) begin
            bus.crc_err <= 1'b0;
        end else if (bus.crc_en && any_miss) begin
            bus.crc_err <= 1'b1;  // held until the end bit is checked
        end
    end

endmodule

// ==== verilog/sdio_rx_deser.sv ====
`include "sdio_macros.svh"

module sdio_rx_deser import sdio_pkg::*; (
    input  logic         sd_clk,
    sdio_rx_if.deser_mp  bus,
    output byte_t        dma_rx_buf_o
);

    bit_idx_t bit_pos;
    logic     high_nibble;

    // msb arrives first on DAT0
    assign bit_pos = bit_idx_t'(`SDIO_BYTE_W - 1) - bus.bit_idx;

    // 4-bit mode, sample 0 carries bits 7..4
    assign high_nibble = (bus.bit_idx[0] == 1'b0);

    always_ff @(posedge sd_clk) begin
        if (bus.data_en) begin
            if (!bus.width4) begin
                dma_rx_buf_o[bit_pos] <= bus.lanes[0];
            end else if (high_nibble) begin
                dma_rx_buf_o[`SDIO_BYTE_W-1 -: `SDIO_LANES] <= bus.lanes;
            end else begin
                dma_rx_buf_o[`SDIO_LANES-1:0] <= bus.lanes;
            end
        end
    end

endmodule

// ==== verilog/sdio_rx_fsm.sv ====
`include "sdio_macros.svh"

module sdio_rx_fsm import sdio_pkg::*; (
    input  logic       sd_clk,
    input  logic       rstn,
    input  logic       sd_rst_i,
    input  blk_field_t block_size_i,            // bytes per block
    input  blk_field_t block_count_i,           // 0: infinite
    input  logic       blk_gap_stop_i,
    input  logic       blk_gap_clk_en_i,        // 0: pause card clock in gap stop
    input  logic       blk_gap_read_wait_en_i,
    input  logic       rx_en_i,                 // card clock sample qualifier
    input  logic       dat_start_i,
    input  logic       dma_rx_buf_rdy_i,
    input  logic       dma_rx_buf_empty_i,
    sdio_rx_if.fsm_mp  bus,
    output logic       dma_rx_buf_wr_o,
    output logic       dat2_o,
    output logic       dat2_oe_o,
    output logic       dat_crc_err_event_o,
    output logic       dat_end_err_event_o,
    output logic       blk_gap_event_o,
    output logic       dat_busy_o,
    output logic       dat_done_o,
    output logic       sd_clk_pause_o,
    output logic       tmout_wait_rx_start_en_o
);

    rx_state_t  state_q;
    rx_state_t  state_d;
    bit_idx_t   bit_cnt;
    blk_field_t byte_cnt;
    crc_idx_t   crc_cnt;
    blk_field_t blk_cnt;
    bit_idx_t   bit_max;
    logic       last_bit;
    logic       last_byte;
    logic       last_crc;
    logic       last_blk;
    logic       start_bit;
    logic       end_bit_ok;
    logic       read_wait;

    // 2 samples per byte on 4 lanes, 8 on DAT0
    assign bit_max   = bus.width4 ? bit_idx_t'(1) : bit_idx_t'(`SDIO_BYTE_W - 1);
    assign last_bit  = (bit_cnt == bit_max);
    assign last_byte = (byte_cnt == block_size_i);  // byte_cnt already counts this byte
    assign last_crc  = (crc_cnt == crc_idx_t'(`SDIO_CRC_LEN - 1));
    assign last_blk  = (block_count_i != '0) && (blk_cnt == block_count_i);

    // start bit low and end bit high on every active lane
    assign start_bit  = bus.width4 ? (bus.lanes == '0) : ~bus.lanes[0];
    assign end_bit_ok = bus.width4 ? (bus.lanes == '1) : bus.lanes[0];

    // hold DAT2 low so the card stops sending during the gap
    assign read_wait = (state_q == RX_BLK_GAP_STOP) && !last_blk &&
                       blk_gap_stop_i && blk_gap_read_wait_en_i;

    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn) begin
            state_q <= IDLE;
        end else if (sd_rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (dat_start_i) begin
                    state_d = RX_START_BIT;
                end
            end
            RX_START_BIT: begin
                if (rx_en_i && start_bit) begin
                    state_d = RX_DATA_BYTE;
                end
            end
            RX_DATA_BYTE: begin
                if (rx_en_i && last_bit) begin
                    state_d = DMA_RX_BYTE_WR;
                end
            end
            DMA_RX_BYTE_WR: begin
                // no rx_en here, the card clock is stopped
                if (dma_rx_buf_rdy_i) begin
                    state_d = last_byte ? RX_CRC : RX_DATA_BYTE;
                end
            end
            RX_CRC: begin
                if (rx_en_i && last_crc) begin
                    state_d = RX_END_BIT;
                end
            end
            RX_END_BIT: begin
                if (rx_en_i) begin
                    state_d = RX_BLK_GAP_STOP;
                end
            end
            RX_BLK_GAP_STOP: begin
                if (last_blk) begin
                    state_d = RX_WAIT_DMA;
                end else if (!blk_gap_stop_i) begin
                    state_d = RX_START_BIT;  // next block
                end
            end
            RX_WAIT_DMA: begin
                if (dma_rx_buf_empty_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn) begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
            crc_cnt  <= '0;
            blk_cnt  <= '0;
        end else if (sd_rst_i || state_q == IDLE) begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
            crc_cnt  <= '0;
            blk_cnt  <= '0;
        end else begin
            case (state_q)
                RX_START_BIT: begin
                    if (rx_en_i && start_bit) begin  // fresh counts per block
                        bit_cnt  <= '0;
                        byte_cnt <= '0;
                        crc_cnt  <= '0;
                    end
                end
                RX_DATA_BYTE: begin
                    if (rx_en_i) begin
                        if (last_bit) begin
                            bit_cnt  <= '0;
                            byte_cnt <= byte_cnt + 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                RX_CRC: begin
                    if (rx_en_i) begin
                        crc_cnt <= crc_cnt + 1'b1;  // wraps to 0 after the last bit
                    end
                end
                RX_END_BIT: begin
                    if (rx_en_i) begin
                        blk_cnt <= blk_cnt + 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn) begin
            dma_rx_buf_wr_o <= 1'b0;
            dat2_o          <= 1'b1;
            dat2_oe_o       <= 1'b0;
        end else if (sd_rst_i) begin
            dma_rx_buf_wr_o <= 1'b0;
            dat2_o          <= 1'b1;
            dat2_oe_o       <= 1'b0;
        end else begin
            dma_rx_buf_wr_o <= (state_q == DMA_RX_BYTE_WR) && dma_rx_buf_rdy_i;
            dat2_o          <= ~read_wait;
            dat2_oe_o       <= read_wait;
        end
    end

    assign bus.data_en   = (state_q == RX_DATA_BYTE) && rx_en_i;
    assign bus.crc_en    = (state_q == RX_CRC) && rx_en_i;
    assign bus.blk_start = (state_q == RX_START_BIT);
    assign bus.bit_idx   = bit_cnt;
    assign bus.crc_idx   = crc_cnt;

    // end bit sample events
    assign dat_crc_err_event_o = (state_q == RX_END_BIT) && rx_en_i && bus.crc_err;
    assign dat_end_err_event_o = (state_q == RX_END_BIT) && rx_en_i && !end_bit_ok;
    assign blk_gap_event_o     = (state_q == RX_END_BIT) && rx_en_i;

    assign dat_busy_o = (state_q != IDLE);
    assign dat_done_o = (state_q == RX_WAIT_DMA) && dma_rx_buf_empty_i;

    assign sd_clk_pause_o = (state_q == DMA_RX_BYTE_WR) ||
                            ((state_q == RX_BLK_GAP_STOP) && !blk_gap_clk_en_i);

    assign tmout_wait_rx_start_en_o = (state_q == RX_START_BIT);

endmodule

// ==== verilog/sdio_rx_if.sv ====
`include "sdio_macros.svh"

interface sdio_rx_if import sdio_pkg::*; ();

    lanes_t   lanes;        // sampled DAT3..DAT0
    logic     width4;       // 1: 4-bit bus, 0: DAT0 only
    logic     data_en;      // one qualified data sample
    logic     crc_en;       // one qualified crc sample
    logic     blk_start;    // waiting for the start bit
    bit_idx_t bit_idx;
    crc_idx_t crc_idx;
    logic     crc_err;      // sticky until next block start

    modport fsm_mp (
        input  lanes, width4, crc_err,
        output data_en, crc_en, blk_start, bit_idx, crc_idx
    );

    modport deser_mp (
        input  lanes, width4, data_en, bit_idx
    );

    modport crc_mp (
        input  lanes, width4, data_en, crc_en, blk_start, crc_idx,
        output crc_err
    );

endinterface

// ==== verilog/sdio_pkg.sv ====
`include "sdio_macros.svh"

package sdio_pkg;

    typedef logic [`SDIO_BYTE_W-1:0]  byte_t;
    typedef logic [`SDIO_BLK_W-1:0]   blk_field_t;   // block size / block count
    typedef logic [`SDIO_LANES-1:0]   lanes_t;       // one sample of DAT3..DAT0
    typedef logic [`SDIO_CRC_LEN-1:0] crc_t;

    // bit position inside a byte, also the nibble select in 4-bit mode
    typedef logic [$clog2(`SDIO_BYTE_W)-1:0]  bit_idx_t;
    typedef logic [$clog2(`SDIO_CRC_LEN)-1:0] crc_idx_t;

    // read path states
    typedef enum logic [2:0] {
        IDLE,
        RX_START_BIT,       // timeout counter runs here
        RX_DATA_BYTE,
        DMA_RX_BYTE_WR,     // card clock paused
        RX_CRC,
        RX_END_BIT,
        RX_BLK_GAP_STOP,
        RX_WAIT_DMA
    } rx_state_t;

endpackage

// ==== include/sdio_macros.svh ====
`ifndef SDIO_MACROS_SVH
`define SDIO_MACROS_SVH

// crc16 per data lane
`define SDIO_CRC_LEN    16

// one data byte
`define SDIO_BYTE_W     8

// block size and block count register fields
`define SDIO_BLK_W      16

// DAT3..DAT0
`define SDIO_LANES      4

`endif
